// File: common/dnc_pkg.sv
// Shared fixed-point widths, scratch memory map and access struct, imported by every RTL module
`default_nettype none

package dnc_pkg;

  ////////////////////////////////////////
  // Fixed-point format
  ////////////////////////////////////////

  // Two's complement word, 8 fraction bits
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_BITS  = 8;

  // 1.0 in this format
  localparam logic [DATA_WIDTH-1:0] ONE_FIXED = 16'd256;

  // Longest vector the host may ask for
  localparam int MAX_N = 16;

  ////////////////////////////////////////
  // Scratch memory map
  ////////////////////////////////////////

  localparam int ADDR_WIDTH = 6;

  // Three regions of MAX_N words each
  localparam int MEM_DEPTH = 3 * MAX_N;

  // w(t), written by the loader
  localparam logic [ADDR_WIDTH-1:0] W_BASE = 6'd0;
  // p(t-1), written by the loader
  localparam logic [ADDR_WIDTH-1:0] P_BASE = 6'd16;
  // Scaled p(t-1), written by the multiplier
  localparam logic [ADDR_WIDTH-1:0] Q_BASE = 6'd32;

  ////////////////////////////////////////
  // Arbiter requesters
  ////////////////////////////////////////

  localparam int N_REQ = 4;

  // Priority order, lowest index wins
  localparam int REQ_LOAD = 0;
  localparam int REQ_SUM  = 1;
  localparam int REQ_MUL  = 2;
  localparam int REQ_ADD  = 3;

  // One scratch access
  typedef struct packed {
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// File: verilog/dnc_scratch_memory.sv
// Single-port scratch RAM shared by all vector units, written and read through the arbiter
`timescale 1ns/10ps
`default_nettype none

module dnc_scratch_memory import dnc_pkg::*; (
  input  wire logic                  CLK,
  input  mem_req_t                   req,
  input  wire logic                  en,
  output logic      [DATA_WIDTH-1:0] rdata
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Holds the w, p(t-1) and scaled regions
  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

  ////////////////////////////////////////
  // Access port
  ////////////////////////////////////////

  // Write on a granted write
  // Registered read, data one cycle after the grant
  always_ff @(posedge CLK) begin
    if (en) begin
      if (req.we) begin
        mem[req.addr] <= req.wdata;
      end else begin
        rdata <= mem[req.addr];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/dnc_memory_arbiter.sv
// Fixed-priority arbiter that grants one scratch memory requester per cycle and flags its read data
`timescale 1ns/10ps
`default_nettype none

module dnc_memory_arbiter import dnc_pkg::*; (
  input  wire logic             CLK,
  input  wire logic             RST,
  input  wire logic [N_REQ-1:0] req,
  input  mem_req_t              req_data [N_REQ],
  output logic      [N_REQ-1:0] gnt,
  output logic      [N_REQ-1:0] rvalid,
  output mem_req_t              mem_req,
  output logic                  mem_en
);

  localparam int SEL_WIDTH = $clog2(N_REQ);

  // Index of the winning requester
  logic [SEL_WIDTH-1:0] sel;

  ////////////////////////////////////////
  // Grant
  ////////////////////////////////////////

  // Any request reaches the memory this cycle
  assign mem_en = |req;

  // Scan from the bottom of the priority list up
  // Last hit is the lowest active index
  always_comb begin
    sel = '0;
    for (int i = N_REQ - 1; i >= 0; i--) begin
      if (req[i]) begin
        sel = SEL_WIDTH'(i);
      end
    end
    gnt = '0;
    if (mem_en) begin
      gnt[sel] = 1'b1;
    end
  end

  // Winner's access goes straight to the RAM
  assign mem_req = req_data[sel];

  ////////////////////////////////////////
  // Read return
  ////////////////////////////////////////

  // RAM read latency is one cycle
  // Remember who was granted a read and flag that requester next cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rvalid <= '0;
    end else if (mem_req.we) begin
      rvalid <= '0;
    end else begin
      rvalid <= gnt;
    end
  end

endmodule

`default_nettype wire

// File: vector/dnc_vector_summation.sv
// Vector summation unit that reads the w(t) region and returns its wrapped sum to the controller
`timescale 1ns/10ps
`default_nettype none

module dnc_vector_summation import dnc_pkg::*; (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  start,
  input  wire logic [4:0]            size_n,
  output logic                       req,
  output mem_req_t                   req_data,
  input  wire logic                  gnt,
  input  wire logic                  rvalid,
  input  wire logic [DATA_WIDTH-1:0] rdata,
  output logic      [DATA_WIDTH-1:0] sum,
  output logic                       done
);

  logic                  busy;
  // Reads issued so far
  logic [4:0]            issue_cnt;
  // Words returned so far
  logic [4:0]            ret_cnt;
  logic [DATA_WIDTH-1:0] acc;

  ////////////////////////////////////////
  // Read requests
  ////////////////////////////////////////

  // Reads stream back to back while granted
  assign req = busy && (issue_cnt != size_n);

  assign req_data = '{we: 1'b0, addr: W_BASE + {1'b0, issue_cnt}, wdata: '0};

  ////////////////////////////////////////
  // Accumulate
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      issue_cnt <= '0;
      ret_cnt   <= '0;
      acc       <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy      <= 1'b1;
        issue_cnt <= '0;
        ret_cnt   <= '0;
        acc       <= '0;
      end else if (busy) begin
        // Next address once the current one is taken
        if (req && gnt) begin
          issue_cnt <= issue_cnt + 5'd1;
        end
        // Wrapping 16-bit sum
        if (rvalid) begin
          acc     <= acc + rdata;
          ret_cnt <= ret_cnt + 5'd1;
          // Nth word back
          if (ret_cnt == size_n - 5'd1) begin
            busy <= 1'b0;
            done <= 1'b1;
          end
        end
      end
    end
  end

  // Valid with done
  assign sum = acc;

endmodule

`default_nettype wire

// File: vector/dnc_vector_multiplier.sv
// Vector multiplier that scales p(t-1) by a fixed-point scalar into the scaled region
`timescale 1ns/10ps
`default_nettype none

module dnc_vector_multiplier import dnc_pkg::*; (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  start,
  input  wire logic [4:0]            size_n,
  input  wire logic [DATA_WIDTH-1:0] scalar,
  output logic                       req,
  output mem_req_t                   req_data,
  input  wire logic                  gnt,
  input  wire logic                  rvalid,
  input  wire logic [DATA_WIDTH-1:0] rdata,
  output logic      [4:0]            mul_count,
  output logic                       done
);

  // Read p, wait for data, write the product
  typedef enum logic [1:0] {
    S_IDLE,
    S_RD,
    S_WAIT,
    S_WR
  } state_t;

  state_t                       state;
  logic signed [2*DATA_WIDTH-1:0] prod;
  logic signed [2*DATA_WIDTH-1:0] scaled;
  logic        [DATA_WIDTH-1:0] prod_q;
  logic        [ADDR_WIDTH-1:0] addr_base;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Full signed product, both operands sign-extended first
  assign prod = (2*DATA_WIDTH)'($signed(rdata)) * (2*DATA_WIDTH)'($signed(scalar));

  // Arithmetic shift, truncates toward minus infinity
  assign scaled = prod >>> FRAC_BITS;

  always_ff @(posedge CLK) begin
    if (state == S_WAIT && rvalid) begin
      prod_q <= scaled[DATA_WIDTH-1:0];
    end
  end

  // mul_count doubles as the element index
  assign addr_base = (state == S_WR) ? Q_BASE : P_BASE;
  assign req       = (state == S_RD) || (state == S_WR);
  assign req_data  = '{we: (state == S_WR), addr: addr_base + {1'b0, mul_count}, wdata: prod_q};

  ////////////////////////////////////////
  // Element sequencer
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= S_IDLE;
      mul_count <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            mul_count <= '0;
            state     <= S_RD;
          end
        end
        S_RD: begin
          if (gnt) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (rvalid) begin
            state <= S_WR;
          end
        end
        S_WR: begin
          // Write lands on this edge, so the adder may read it next cycle
          if (gnt) begin
            mul_count <= mul_count + 5'd1;
            if (mul_count == size_n - 5'd1) begin
              done  <= 1'b1;
              state <= S_IDLE;
            end else begin
              state <= S_RD;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: vector/dnc_vector_adder.sv
// Vector adder that trails the multiplier, adds scaled p and w per element and streams p(t) out
`timescale 1ns/10ps
`default_nettype none

module dnc_vector_adder import dnc_pkg::*; (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  start,
  input  wire logic [4:0]            size_n,
  input  wire logic [4:0]            mul_count,
  output logic                       req,
  output mem_req_t                   req_data,
  input  wire logic                  gnt,
  input  wire logic                  rvalid,
  input  wire logic [DATA_WIDTH-1:0] rdata,
  output logic      [DATA_WIDTH-1:0] p_out,
  output logic                       p_out_enable,
  output logic                       done
);

  // Scaled element first, then w
  typedef enum logic [2:0] {
    S_IDLE,
    S_RD_Q,
    S_WAIT_Q,
    S_RD_W,
    S_WAIT_W
  } state_t;

  state_t                state;
  logic [4:0]            idx;
  logic [DATA_WIDTH-1:0] q_val;
  logic [ADDR_WIDTH-1:0] addr_base;
  logic                  q_ready;

  ////////////////////////////////////////
  // Requests
  ////////////////////////////////////////

  // Element written by the multiplier already
  assign q_ready = (mul_count > idx);

  assign req       = ((state == S_RD_Q) && q_ready) || (state == S_RD_W);
  assign addr_base = (state == S_RD_W) ? W_BASE : Q_BASE;
  assign req_data  = '{we: 1'b0, addr: addr_base + {1'b0, idx}, wdata: '0};

  // Hold the scaled term until w comes back
  always_ff @(posedge CLK) begin
    if (state == S_WAIT_Q && rvalid) begin
      q_val <= rdata;
    end
  end

  ////////////////////////////////////////
  // Element sequencer
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= S_IDLE;
      idx          <= '0;
      p_out        <= '0;
      p_out_enable <= 1'b0;
      done         <= 1'b0;
    end else begin
      p_out_enable <= 1'b0;
      done         <= 1'b0;
      case (state)
        S_IDLE: begin
          // mul_count is not looked at until the next cycle
          if (start) begin
            idx   <= '0;
            state <= S_RD_Q;
          end
        end
        S_RD_Q: begin
          // Stalls here while waiting for mul_count or the grant
          if (gnt) begin
            state <= S_WAIT_Q;
          end
        end
        S_WAIT_Q: begin
          if (rvalid) begin
            state <= S_RD_W;
          end
        end
        S_RD_W: begin
          if (gnt) begin
            state <= S_WAIT_W;
          end
        end
        S_WAIT_W: begin
          if (rvalid) begin
            // Wrapping sum out with its strobe
            p_out        <= q_val + rdata;
            p_out_enable <= 1'b1;
            if (idx == size_n - 5'd1) begin
              done  <= 1'b1;
              state <= S_IDLE;
            end else begin
              idx   <= idx + 5'd1;
              state <= S_RD_Q;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: precedence/dnc_precedence_weighting.sv
// Top level of the precedence weighting block, loads w(t) and p(t-1) and sequences sum, scale and add
`timescale 1ns/10ps
`default_nettype none

module dnc_precedence_weighting import dnc_pkg::*; (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  START,
  output logic                       READY,
  input  wire logic                  W_IN_ENABLE,
  input  wire logic                  P_IN_ENABLE,
  output logic                       P_OUT_ENABLE,
  input  wire logic [4:0]            SIZE_N_IN,
  input  wire logic [DATA_WIDTH-1:0] W_IN,
  input  wire logic [DATA_WIDTH-1:0] P_IN,
  output logic      [DATA_WIDTH-1:0] P_OUT
);

  // Steps of one run
  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD_W,
    S_LOAD_P,
    S_SUM,
    S_SCALE
  } state_t;

  state_t                state;
  logic [4:0]            size_n;
  logic [4:0]            load_cnt;
  logic                  load_w;
  logic                  load_p;
  logic                  load_last;
  logic [DATA_WIDTH-1:0] sum;
  logic [DATA_WIDTH-1:0] k_scalar;
  logic                  sum_start;
  logic                  sum_done;
  logic                  scale_start;
  logic                  mul_done;
  logic                  mul_fin;
  logic                  add_done;
  logic [4:0]            mul_count;

  // Memory side
  logic [N_REQ-1:0]      req;
  logic [N_REQ-1:0]      gnt;
  logic [N_REQ-1:0]      rvalid;
  mem_req_t              req_data [N_REQ];
  mem_req_t              mem_req;
  logic                  mem_en;
  logic [DATA_WIDTH-1:0] rdata;

  ////////////////////////////////////////
  // Input loader
  ////////////////////////////////////////

  // Strobes outside the load steps are dropped
  assign load_w    = (state == S_LOAD_W) && W_IN_ENABLE;
  assign load_p    = (state == S_LOAD_P) && P_IN_ENABLE;
  assign load_last = (load_cnt == size_n - 5'd1);

  // Top priority, granted in the strobe cycle
  assign req[REQ_LOAD]      = load_w || load_p;
  assign req_data[REQ_LOAD] = '{we: 1'b1,
                                addr: (load_p ? P_BASE : W_BASE) + {1'b0, load_cnt},
                                wdata: load_p ? P_IN : W_IN};

  ////////////////////////////////////////
  // Step controller
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= S_IDLE;
      size_n      <= '0;
      load_cnt    <= '0;
      k_scalar    <= '0;
      sum_start   <= 1'b0;
      scale_start <= 1'b0;
      mul_fin     <= 1'b0;
      READY       <= 1'b0;
    end else begin
      sum_start   <= 1'b0;
      scale_start <= 1'b0;
      READY       <= 1'b0;
      case (state)
        S_IDLE: begin
          // Length is fixed for the whole run
          if (START) begin
            size_n   <= SIZE_N_IN;
            load_cnt <= '0;
            state    <= S_LOAD_W;
          end
        end
        S_LOAD_W, S_LOAD_P: begin
          if (req[REQ_LOAD] && gnt[REQ_LOAD]) begin
            if (load_last) begin
              load_cnt <= '0;
              if (state == S_LOAD_P) begin
                sum_start <= 1'b1;
                state     <= S_SUM;
              end else begin
                state <= S_LOAD_P;
              end
            end else begin
              load_cnt <= load_cnt + 5'd1;
            end
          end
        end
        S_SUM: begin
          // k = 1 - sum(w), wraps like every other sum
          if (sum_done) begin
            k_scalar    <= ONE_FIXED - sum;
            scale_start <= 1'b1;
            mul_fin     <= 1'b0;
            state       <= S_SCALE;
          end
        end
        S_SCALE: begin
          // Multiplier and adder run together, adder finishes last
          if (mul_done) begin
            mul_fin <= 1'b1;
          end
          if (add_done && (mul_fin || mul_done)) begin
            READY <= 1'b1;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Shared scratch memory
  ////////////////////////////////////////

  dnc_memory_arbiter u_arbiter (
    .CLK      (CLK),
    .RST      (RST),
    .req      (req),
    .req_data (req_data),
    .gnt      (gnt),
    .rvalid   (rvalid),
    .mem_req  (mem_req),
    .mem_en   (mem_en)
  );

  dnc_scratch_memory u_memory (
    .CLK   (CLK),
    .req   (mem_req),
    .en    (mem_en),
    .rdata (rdata)
  );

  ////////////////////////////////////////
  // Vector units
  ////////////////////////////////////////

  dnc_vector_summation u_summation (
    .CLK      (CLK),
    .RST      (RST),
    .start    (sum_start),
    .size_n   (size_n),
    .req      (req[REQ_SUM]),
    .req_data (req_data[REQ_SUM]),
    .gnt      (gnt[REQ_SUM]),
    .rvalid   (rvalid[REQ_SUM]),
    .rdata    (rdata),
    .sum      (sum),
    .done     (sum_done)
  );

  dnc_vector_multiplier u_multiplier (
    .CLK       (CLK),
    .RST       (RST),
    .start     (scale_start),
    .size_n    (size_n),
    .scalar    (k_scalar),
    .req       (req[REQ_MUL]),
    .req_data  (req_data[REQ_MUL]),
    .gnt       (gnt[REQ_MUL]),
    .rvalid    (rvalid[REQ_MUL]),
    .rdata     (rdata),
    .mul_count (mul_count),
    .done      (mul_done)
  );

  // Output stream goes straight to the ports
  dnc_vector_adder u_adder (
    .CLK          (CLK),
    .RST          (RST),
    .start        (scale_start),
    .size_n       (size_n),
    .mul_count    (mul_count),
    .req          (req[REQ_ADD]),
    .req_data     (req_data[REQ_ADD]),
    .gnt          (gnt[REQ_ADD]),
    .rvalid       (rvalid[REQ_ADD]),
    .rdata        (rdata),
    .p_out        (P_OUT),
    .p_out_enable (P_OUT_ENABLE),
    .done         (add_done)
  );

endmodule

`default_nettype wire

// File: sim/dnc_precedence_tests.svh
// Directed tests for the precedence weighting block, included inside the testbench module

// Random w in [offset, offset+span), p centered on zero
task automatic fill_random(input int n, input logic [DATA_WIDTH-1:0] w_span,
                           input logic [DATA_WIDTH-1:0] w_offset,
                           input logic [DATA_WIDTH-1:0] p_span);
  int i;
  for (i = 0; i < n; i++) begin
    w_vec[i] = random_word(w_span) + w_offset;
    p_vec[i] = random_word(p_span) - (p_span >> 1);
  end
endtask

// Outputs quiet between reset and the first START
task automatic test_reset_idle();
  int i;
  for (i = 0; i < 8; i++) begin
    check_value("READY", DATA_WIDTH'(ready), '0);
    check_value("P_OUT_ENABLE", DATA_WIDTH'(p_out_enable), '0);
    check_value("P_OUT", p_out, '0);
    step_cycle();
  end
endtask

// w all zero gives a scalar of exactly 1.0, so p(t) is p(t-1)
task automatic test_unit_scalar();
  int i;
  p_vec[0] = 16'h0123;
  p_vec[1] = 16'hff80;
  p_vec[2] = 16'h7fff;
  p_vec[3] = 16'h8001;
  for (i = 0; i < 4; i++) begin
    w_vec[i] = '0;
    exp_p[i] = p_vec[i];
  end
  run_vectors(4);
endtask

// Small w keeps the scalar just below 1.0
task automatic test_random_small();
  int r;
  int n;
  for (r = 0; r < 5; r++) begin
    n = 1 + int'(random_word(16'd16));
    fill_random(n, 16'd16, 16'd0, 16'd512);
    compute_expected(n);
    run_vectors(n);
  end
endtask

// Sum of w above 1.0, negative scalar and floor rounding
task automatic test_negative_scalar();
  int n;
  // Sum 1.5, scalar -0.5, half-way products round down
  w_vec[0] = 16'h0100;
  w_vec[1] = 16'h0080;
  w_vec[2] = 16'h0000;
  w_vec[3] = 16'h0000;
  p_vec[0] = 16'h0003;
  p_vec[1] = 16'hfffd;
  p_vec[2] = 16'h0101;
  p_vec[3] = 16'hfeff;
  // -1.5 lsb to -2, 1.5 to 1, -128.5 to -129, 128.5 to 128
  exp_p[0] = 16'h00fe;
  exp_p[1] = 16'h0081;
  exp_p[2] = 16'hff7f;
  exp_p[3] = 16'h0080;
  run_vectors(4);
  n = 2 + int'(random_word(16'd15));
  fill_random(n, 16'd256, 16'h0090, 16'd4096);
  compute_expected(n);
  run_vectors(n);
endtask

// START right after READY, longest and shortest vectors
task automatic test_back_to_back();
  fill_random(16, 16'd32, 16'd0, 16'd1024);
  compute_expected(16);
  run_vectors(16);
  fill_random(1, 16'd512, 16'd0, 16'd2048);
  compute_expected(1);
  run_vectors(1);
  fill_random(16, 16'd64, 16'd0, 16'd8192);
  compute_expected(16);
  run_vectors(16);
endtask

// Strobes while idle must not reach the scratch memory
task automatic test_idle_strobes();
  int i;
  fill_random(5, 16'd48, 16'd0, 16'd1024);
  compute_expected(5);
  for (i = 0; i < 6; i++) begin
    w_in_enable = 1'b1;
    p_in_enable = i[0];
    w_in        = random_word(16'hffff);
    p_in        = random_word(16'hffff);
    step_cycle();
    check_value("READY", DATA_WIDTH'(ready), '0);
    check_value("P_OUT_ENABLE", DATA_WIDTH'(p_out_enable), '0);
  end
  w_in_enable = 1'b0;
  p_in_enable = 1'b0;
  run_vectors(5);
endtask

// File: sim/dnc_precedence_tb.sv
// Testbench for the precedence weighting block, the simulation top that runs every directed test
`timescale 1ns/10ps
`default_nettype none

module dnc_precedence_tb import dnc_pkg::*; ();

  ////////////////////////////////////////
  // Clock, reset and run limit
  ////////////////////////////////////////

  localparam int CLK_HALF     = 2;
  localparam int RESET_CYCLES = 10;
  // 12 runs of up to about 150 cycles, idle checks, plenty of margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic                  CLK = 1'b0;
  logic                  RST;
  logic                  start;
  logic                  ready;
  logic                  w_in_enable;
  logic                  p_in_enable;
  logic                  p_out_enable;
  logic [4:0]            size_n_in;
  logic [DATA_WIDTH-1:0] w_in;
  logic [DATA_WIDTH-1:0] p_in;
  logic [DATA_WIDTH-1:0] p_out;

  // Stimulus vectors and expected p(t)
  logic [DATA_WIDTH-1:0] w_vec [MAX_N];
  logic [DATA_WIDTH-1:0] p_vec [MAX_N];
  logic [DATA_WIDTH-1:0] exp_p [MAX_N];

  logic [31:0] lcg_state;
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  // Length of the run in progress and strobes seen so far
  int          run_n;
  int          out_count;

  always #CLK_HALF CLK = ~CLK;

  dnc_precedence_weighting u_dut (
    .CLK          (CLK),
    .RST          (RST),
    .START        (start),
    .READY        (ready),
    .W_IN_ENABLE  (w_in_enable),
    .P_IN_ENABLE  (p_in_enable),
    .P_OUT_ENABLE (p_out_enable),
    .SIZE_N_IN    (size_n_in),
    .W_IN         (w_in),
    .P_IN         (p_in),
    .P_OUT        (p_out)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // LCG, upper bits are the useful ones
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] random_word(input logic [DATA_WIDTH-1:0] span);
    logic [31:0] r;
    r = next_random();
    return r[31:16] % span;
  endfunction

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] actual,
                             input logic [DATA_WIDTH-1:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  // Inputs change and outputs are read 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge CLK);
    #1;
  endtask

  // p(t;j) = (1 - sum w)*p(t-1;j) + w(t;j), product floored, sums wrap at 16 bits
  task automatic compute_expected(input int n);
    int                    i;
    int                    k_val;
    int                    product;
    int                    scaled;
    logic [DATA_WIDTH-1:0] w_total;
    w_total = '0;
    for (i = 0; i < n; i++) begin
      w_total = w_total + w_vec[i];
    end
    // 1.0 minus the sum, as a signed scalar
    k_val = int'($signed(16'h0100 - w_total));
    for (i = 0; i < n; i++) begin
      product = int'($signed(p_vec[i])) * k_val;
      scaled  = product / 256;
      // Division rounds toward zero, step down for negative remainders
      if (product < 0 && product % 256 != 0) begin
        scaled = scaled - 1;
      end
      exp_p[i] = DATA_WIDTH'(scaled) + w_vec[i];
    end
  endtask

  // Compare one output strobe against the next expected element
  task automatic sample_outputs();
    if (p_out_enable) begin
      if (out_count < run_n) begin
        check_value($sformatf("P_OUT[%0d]", out_count), p_out, exp_p[out_count]);
      end else begin
        error_count++;
        $display("Extra P_OUT_ENABLE strobe after all %0d elements were seen", run_n);
      end
      out_count++;
    end
  endtask

  // One full run: START, N words of w, N words of p, then outputs until READY
  task automatic run_vectors(input int n);
    int i;
    run_n       = n;
    out_count   = 0;
    start       = 1'b1;
    size_n_in   = 5'(n);
    step_cycle();
    sample_outputs();
    start = 1'b0;
    for (i = 0; i < n; i++) begin
      w_in_enable = 1'b1;
      w_in        = w_vec[i];
      step_cycle();
      sample_outputs();
    end
    w_in_enable = 1'b0;
    for (i = 0; i < n; i++) begin
      p_in_enable = 1'b1;
      p_in        = p_vec[i];
      step_cycle();
      sample_outputs();
    end
    p_in_enable = 1'b0;
    while (!ready) begin
      step_cycle();
      sample_outputs();
    end
    check_value("P_OUT_ENABLE count", DATA_WIDTH'(out_count), DATA_WIDTH'(n));
  endtask

  `include "dnc_precedence_tests.svh"

  ////////////////////////////////////////
  // Timeout
  ////////////////////////////////////////

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    RST         = 1'b1;
    start       = 1'b0;
    w_in_enable = 1'b0;
    p_in_enable = 1'b0;
    size_n_in   = '0;
    w_in        = '0;
    p_in        = '0;
    lcg_state   = 32'hd3dd_b28c;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    RST = 1'b0;
    test_reset_idle();
    test_unit_scalar();
    test_random_small();
    test_negative_scalar();
    test_back_to_back();
    test_idle_strobes();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+sim
common/dnc_pkg.sv
verilog/dnc_scratch_memory.sv
verilog/dnc_memory_arbiter.sv
vector/dnc_vector_summation.sv
vector/dnc_vector_multiplier.sv
vector/dnc_vector_adder.sv
precedence/dnc_precedence_weighting.sv
sim/dnc_precedence_tb.sv

// File: Makefile
# Verilator flow for the precedence weighting block

TOP := dnc_precedence_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module dnc_precedence_weighting
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
